// File: hw/conv_feed_pkg.sv
`default_nettype none

package conv_feed_pkg;

    ////////////////////////////////////////////////////////////
    // Array geometry and data sizes
    ////////////////////////////////////////////////////////////

    localparam int LANES  = 16;
    localparam int WORD_W = 8;
    localparam int KSIZE  = 3;

    // Both input memories share one address width
    localparam int ADDR_W         = 12;
    localparam int AMEM_DEPTH_DEF = 4096;
    localparam int WMEM_DEPTH_DEF = 4096;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        lane_t;

    // Highest lane index, closes every step
    localparam lane_t LANE_LAST = lane_t'(LANES - 1);

    typedef enum logic [1:0] {
        MODE_CFG = 2'd0,
        MODE_WGT = 2'd1,
        MODE_ACT = 2'd2,
        MODE_RUN = 2'd3
    } mode_e;

    // Field order matches the host load order
    typedef struct packed {
        word_t out_ch;
        word_t in_ch;
        word_t width;
        word_t height;
    } cfg_t;

    // Valid kernel positions in one channel plane
    function automatic logic [15:0] num_windows(cfg_t c);
        return (16'(c.width) - 16'(KSIZE - 1)) * (16'(c.height) - 16'(KSIZE - 1));
    endfunction

endpackage

`default_nettype wire

// File: hw/tap_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tap_if
    import conv_feed_pkg::*;
();

    // One lane slot per cycle while compute runs
    logic       issue;
    lane_t      lane;
    // Kernel tap of the current step
    logic [7:0] kch;
    logic [1:0] krow;
    logic [1:0] kcol;
    // Lane 0 of the first tap in a group
    logic       new_group;
    // Drain steps carry zeros only
    logic       flush;
    // Lane 15 of the last drain step
    logic       is_final;

    modport src (output issue, lane, kch, krow, kcol, new_group, flush, is_final);
    modport dst (input issue, lane, kch, krow, kcol, new_group, flush, is_final);

endinterface

`default_nettype wire

// File: hw/tap_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tap_sequencer
    import conv_feed_pkg::*;
(
    input  wire        clk,
    input  wire        rstn,
    input  wire        enable,
    input  wire mode_e mode,
    input  wire        data_load,
    input  wire word_t data_in,
    output cfg_t       cfg,
    output logic       act_wr,
    output logic       wgt_wr,
    output word_t      wr_data,
    tap_if.src         taps
);

    localparam logic [1:0] K_LAST     = 2'(KSIZE - 1);
    localparam logic [3:0] FLUSH_LAST = 4'(LANES - 2);

    logic [2:0]  cfg_cnt;
    logic [15:0] n_win;
    logic [11:0] n_grp;
    lane_t       lane_cnt;
    logic [1:0]  kcol_cnt;
    logic [1:0]  krow_cnt;
    logic [7:0]  kch_cnt;
    logic [11:0] grp_cnt;
    logic [3:0]  flush_cnt;
    logic        flushing;
    logic        seq_done;
    logic        run_ok;
    logic        tap_first;

    // Groups of 16 windows, rounded up
    assign n_win = num_windows(cfg);
    assign n_grp = 12'((n_win + 16'd15) >> 4);

    // Compute only after all four config bytes are in
    assign run_ok    = enable && (mode == MODE_RUN) && (cfg_cnt == 3'd4) && !seq_done;
    assign tap_first = (kch_cnt == 8'd0) && (krow_cnt == 2'd0) && (kcol_cnt == 2'd0);

    ////////////////////////////////////////////////////////////
    // Configuration bytes and load strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg     <= '0;
            cfg_cnt <= '0;
            act_wr  <= 1'b0;
            wgt_wr  <= 1'b0;
        end else begin
            act_wr <= enable && data_load && (mode == MODE_ACT);
            wgt_wr <= enable && data_load && (mode == MODE_WGT);
            // Counter stops after the fourth byte
            if (enable && data_load && (mode == MODE_CFG) && (cfg_cnt != 3'd4)) begin
                case (cfg_cnt)
                    3'd0:    cfg.out_ch <= data_in;
                    3'd1:    cfg.in_ch  <= data_in;
                    3'd2:    cfg.width  <= data_in;
                    default: cfg.height <= data_in;
                endcase
                cfg_cnt <= cfg_cnt + 3'd1;
            end
        end
    end

    // Byte goes out with its strobe
    always_ff @(posedge clk) begin
        wr_data <= data_in;
    end

    ////////////////////////////////////////////////////////////
    // Lane, tap, group and drain schedule
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            taps.issue     <= 1'b0;
            taps.lane      <= '0;
            taps.kch       <= '0;
            taps.krow      <= '0;
            taps.kcol      <= '0;
            taps.new_group <= 1'b0;
            taps.flush     <= 1'b0;
            taps.is_final  <= 1'b0;
            lane_cnt       <= '0;
            kcol_cnt       <= '0;
            krow_cnt       <= '0;
            kch_cnt        <= '0;
            grp_cnt        <= '0;
            flush_cnt      <= '0;
            flushing       <= 1'b0;
            seq_done       <= 1'b0;
        end else begin
            taps.issue <= run_ok;
            if (run_ok) begin
                taps.lane      <= lane_cnt;
                taps.kch       <= kch_cnt;
                taps.krow      <= krow_cnt;
                taps.kcol      <= kcol_cnt;
                taps.new_group <= !flushing && tap_first && (lane_cnt == '0);
                taps.flush     <= flushing;
                taps.is_final  <= flushing && (flush_cnt == FLUSH_LAST) &&
                                  (lane_cnt == LANE_LAST);
                lane_cnt <= lane_cnt + 4'd1;
                if (lane_cnt == LANE_LAST) begin
                    if (flushing) begin
                        flush_cnt <= flush_cnt + 4'd1;
                        if (flush_cnt == FLUSH_LAST) begin
                            seq_done <= 1'b1;
                        end
                    end else if (kcol_cnt != K_LAST) begin
                        kcol_cnt <= kcol_cnt + 2'd1;
                    end else begin
                        // Column, then row, then channel
                        kcol_cnt <= '0;
                        if (krow_cnt != K_LAST) begin
                            krow_cnt <= krow_cnt + 2'd1;
                        end else begin
                            krow_cnt <= '0;
                            if (kch_cnt != cfg.in_ch - 8'd1) begin
                                kch_cnt <= kch_cnt + 8'd1;
                            end else begin
                                kch_cnt <= '0;
                                grp_cnt <= grp_cnt + 12'd1;
                                // Last group done, start the drain
                                if (grp_cnt == n_grp - 12'd1) begin
                                    flushing <= 1'b1;
                                end
                            end
                        end
                    end
                end
            end
        end
    end

    // Issued taps rely on a configuration inside the supported range
    a_cfg_range: assert property (@(posedge clk) disable iff (!rstn)
        taps.issue |-> (cfg.in_ch >= 8'd1) && (cfg.in_ch <= 8'd4) &&
                       (cfg.width >= 8'd3) && (cfg.width <= 8'd20) &&
                       (cfg.height >= 8'd3) && (cfg.height <= 8'd20) &&
                       (cfg.out_ch >= 8'd1) && (cfg.out_ch <= 8'd16));

endmodule

`default_nettype wire

// File: hw/act_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module act_feeder
    import conv_feed_pkg::*;
#(
    parameter int AMEM_DEPTH = AMEM_DEPTH_DEF
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire cfg_t  cfg,
    input  wire        act_wr,
    input  wire word_t wr_data,
    tap_if.dst         taps,
    output logic       lane_valid,
    output lane_t      lane_idx,
    output word_t      lane_data,
    output logic       step_final
);

    word_t             mem [AMEM_DEPTH];
    word_t             mem_q;
    logic [ADDR_W-1:0] wr_ptr;
    logic [15:0]       n_win;
    logic [15:0]       plane;
    // First window of the current group
    logic [7:0]        base_col;
    logic [7:0]        base_row;
    logic [15:0]       base_idx;
    // Window after the last issued lane
    logic [7:0]        nxt_col;
    logic [7:0]        nxt_row;
    logic [15:0]       nxt_idx;
    logic              use_base;
    logic [7:0]        cur_col;
    logic [7:0]        cur_row;
    logic [15:0]       cur_idx;
    logic              cur_zero;
    logic [15:0]       cur_addr;
    logic [15:0]       rd_addr;
    logic              s1_valid;
    lane_t             s1_lane;
    logic              s1_zero;
    logic              s1_final;
    logic              s2_zero;

    assign n_win = num_windows(cfg);
    assign plane = cfg.width * cfg.height;

    // Lane 0 restarts at the group base unless a new group begins
    assign use_base = (taps.lane == '0) && !taps.new_group;
    assign cur_col  = use_base ? base_col : nxt_col;
    assign cur_row  = use_base ? base_row : nxt_row;
    assign cur_idx  = use_base ? base_idx : nxt_idx;

    // Windows past the end and drain steps read as zero
    assign cur_zero = taps.flush || (cur_idx >= n_win);
    assign cur_addr = taps.kch * plane + (cur_row + taps.krow) * cfg.width +
                      cur_col + taps.kcol;

    ////////////////////////////////////////////////////////////
    // Window cursor and address register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            base_col <= '0;
            base_row <= '0;
            base_idx <= '0;
            nxt_col  <= '0;
            nxt_row  <= '0;
            nxt_idx  <= '0;
            s1_valid <= 1'b0;
            s1_lane  <= '0;
            s1_zero  <= 1'b1;
            s1_final <= 1'b0;
            rd_addr  <= '0;
        end else begin
            s1_valid <= taps.issue;
            if (taps.issue) begin
                if (taps.new_group) begin
                    base_col <= cur_col;
                    base_row <= cur_row;
                    base_idx <= cur_idx;
                end
                // Step one window, column wraps at width-2
                nxt_idx <= cur_idx + 16'd1;
                if (cur_col == cfg.width - 8'd3) begin
                    nxt_col <= '0;
                    nxt_row <= cur_row + 8'd1;
                end else begin
                    nxt_col <= cur_col + 8'd1;
                    nxt_row <= cur_row;
                end
                s1_lane  <= taps.lane;
                s1_zero  <= cur_zero;
                s1_final <= taps.is_final;
                rd_addr  <= cur_zero ? '0 : cur_addr;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory and output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (act_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (act_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        mem_q <= mem[rd_addr[ADDR_W-1:0]];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane_valid <= 1'b0;
            lane_idx   <= '0;
            s2_zero    <= 1'b1;
            step_final <= 1'b0;
        end else begin
            lane_valid <= s1_valid;
            lane_idx   <= s1_lane;
            s2_zero    <= !s1_valid || s1_zero;
            step_final <= s1_valid && s1_final;
        end
    end

    assign lane_data = s2_zero ? '0 : mem_q;

    // Real windows address inside the loaded image
    a_addr_range: assert property (@(posedge clk) disable iff (!rstn)
        taps.issue && !cur_zero |=> rd_addr < AMEM_DEPTH);

endmodule

`default_nettype wire

// File: hw/wgt_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module wgt_feeder
    import conv_feed_pkg::*;
#(
    parameter int WMEM_DEPTH = WMEM_DEPTH_DEF
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire cfg_t  cfg,
    input  wire        wgt_wr,
    input  wire word_t wr_data,
    tap_if.dst         taps,
    output logic       lane_valid,
    output lane_t      lane_idx,
    output word_t      lane_data
);

    localparam int KAREA = KSIZE * KSIZE;

    word_t             mem [WMEM_DEPTH];
    word_t             mem_q;
    logic [ADDR_W-1:0] wr_ptr;
    logic [15:0]       cur_addr;
    logic              cur_zero;
    logic [ADDR_W-1:0] rd_addr;
    logic              s1_valid;
    lane_t             s1_lane;
    logic              s1_zero;
    logic              s2_zero;

    // Kernel of lane k starts at k*9*in_ch
    assign cur_addr = 16'(taps.lane * KAREA * cfg.in_ch + taps.kch * KAREA +
                          taps.krow * KSIZE + taps.kcol);
    // Lanes past the last output channel get no kernel
    assign cur_zero = taps.flush || (8'(taps.lane) >= cfg.out_ch);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            s1_valid   <= 1'b0;
            s1_lane    <= '0;
            s1_zero    <= 1'b1;
            rd_addr    <= '0;
            lane_valid <= 1'b0;
            lane_idx   <= '0;
            s2_zero    <= 1'b1;
        end else begin
            if (wgt_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Address stage
            s1_valid <= taps.issue;
            if (taps.issue) begin
                s1_lane <= taps.lane;
                s1_zero <= cur_zero;
                rd_addr <= cur_zero ? '0 : cur_addr[ADDR_W-1:0];
            end
            // Read stage
            lane_valid <= s1_valid;
            lane_idx   <= s1_lane;
            s2_zero    <= !s1_valid || s1_zero;
        end
    end

    always_ff @(posedge clk) begin
        if (wgt_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        mem_q <= mem[rd_addr];
    end

    assign lane_data = s2_zero ? '0 : mem_q;

endmodule

`default_nettype wire

// File: hw/skew_stage.sv
`timescale 1ns/1ps
`default_nettype none

module skew_stage
    import conv_feed_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,
    input  wire               a_valid,
    input  wire lane_t        a_idx,
    input  wire word_t        a_data,
    input  wire               a_final,
    input  wire               w_valid,
    input  wire lane_t        w_idx,
    input  wire word_t        w_data,
    output word_t [LANES-1:0] aouts,
    output word_t [LANES-1:0] wouts,
    output logic              fire,
    output logic              done
);

    // Lanes 0..14 of the step being gathered
    word_t a_step [LANES-1];
    word_t w_step [LANES-1];
    logic  step_end;
    logic  last_q;

    // Lane 15 closes the step and arrives straight from the feeders
    assign step_end = a_valid && (a_idx == LANE_LAST);

    always_ff @(posedge clk) begin
        if (a_valid && (a_idx != LANE_LAST)) begin
            a_step[a_idx] <= a_data;
        end
        if (w_valid && (w_idx != LANE_LAST)) begin
            w_step[w_idx] <= w_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Diagonal skew, lane i lags by i steps
    ////////////////////////////////////////////////////////////

    for (genvar gi = 0; gi < LANES; gi++) begin : g_lane
        word_t a_in;
        word_t w_in;
        word_t a_q;
        word_t w_q;

        if (gi == LANES - 1) begin : g_tail
            assign a_in = a_data;
            assign w_in = w_data;
        end else begin : g_body
            assign a_in = a_step[gi];
            assign w_in = w_step[gi];
        end

        if (gi == 0) begin : g_direct
            always_ff @(posedge clk) begin
                if (!rstn) begin
                    a_q <= '0;
                    w_q <= '0;
                end else if (step_end) begin
                    a_q <= a_in;
                    w_q <= w_in;
                end
            end
        end else begin : g_delay
            // Starts at zero, so the first outputs are zero padding
            word_t a_line [gi];
            word_t w_line [gi];
            always_ff @(posedge clk) begin
                if (!rstn) begin
                    a_q <= '0;
                    w_q <= '0;
                    for (int j = 0; j < gi; j++) begin
                        a_line[j] <= '0;
                        w_line[j] <= '0;
                    end
                end else if (step_end) begin
                    a_q       <= a_line[gi-1];
                    w_q       <= w_line[gi-1];
                    a_line[0] <= a_in;
                    w_line[0] <= w_in;
                    for (int j = 1; j < gi; j++) begin
                        a_line[j] <= a_line[j-1];
                        w_line[j] <= w_line[j-1];
                    end
                end
            end
        end

        assign aouts[gi] = a_q;
        assign wouts[gi] = w_q;
    end

    // Fire with the new outputs, done one cycle after the last fire
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fire   <= 1'b0;
            last_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            fire   <= step_end;
            last_q <= step_end && a_final;
            if (last_q) begin
                done <= 1'b1;
            end
        end
    end

    // Both feeders share one schedule and one pipeline depth
    a_lanes_aligned: assert property (@(posedge clk) disable iff (!rstn)
        (a_valid == w_valid) && (!a_valid || (a_idx == w_idx)));

endmodule

`default_nettype wire

// File: hw/conv_feed_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_feed_top
    import conv_feed_pkg::*;
#(
    parameter int AMEM_DEPTH = AMEM_DEPTH_DEF,
    parameter int WMEM_DEPTH = WMEM_DEPTH_DEF
) (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    enable,
    input  wire [1:0]              mode,
    input  wire                    data_load,
    input  wire [7:0]              data_in,
    output wire [LANES*WORD_W-1:0] aouts,
    output wire [LANES*WORD_W-1:0] wouts,
    output wire                    fire,
    output wire                    done
);

    cfg_t  cfg;
    logic  act_wr;
    logic  wgt_wr;
    word_t wr_data;
    // Activation lane stream
    logic  a_valid;
    lane_t a_idx;
    word_t a_data;
    logic  a_final;
    // Weight lane stream
    logic  w_valid;
    lane_t w_idx;
    word_t w_data;

    tap_if u_taps ();

    tap_sequencer u_seq (
        .clk       (clk),
        .rstn      (rstn),
        .enable    (enable),
        .mode      (mode_e'(mode)),
        .data_load (data_load),
        .data_in   (data_in),
        .cfg       (cfg),
        .act_wr    (act_wr),
        .wgt_wr    (wgt_wr),
        .wr_data   (wr_data),
        .taps      (u_taps.src)
    );

    act_feeder #(.AMEM_DEPTH(AMEM_DEPTH)) u_act (
        .clk        (clk),
        .rstn       (rstn),
        .cfg        (cfg),
        .act_wr     (act_wr),
        .wr_data    (wr_data),
        .taps       (u_taps.dst),
        .lane_valid (a_valid),
        .lane_idx   (a_idx),
        .lane_data  (a_data),
        .step_final (a_final)
    );

    wgt_feeder #(.WMEM_DEPTH(WMEM_DEPTH)) u_wgt (
        .clk        (clk),
        .rstn       (rstn),
        .cfg        (cfg),
        .wgt_wr     (wgt_wr),
        .wr_data    (wr_data),
        .taps       (u_taps.dst),
        .lane_valid (w_valid),
        .lane_idx   (w_idx),
        .lane_data  (w_data)
    );

    skew_stage u_skew (
        .clk     (clk),
        .rstn    (rstn),
        .a_valid (a_valid),
        .a_idx   (a_idx),
        .a_data  (a_data),
        .a_final (a_final),
        .w_valid (w_valid),
        .w_idx   (w_idx),
        .w_data  (w_data),
        .aouts   (aouts),
        .wouts   (wouts),
        .fire    (fire),
        .done    (done)
    );

endmodule

`default_nettype wire

// File: bench/conv_feed_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_feed_tb
    import conv_feed_pkg::*;
();

    localparam int RUNS         = 3;
    localparam int PAUSE_BUDGET = 300;
    localparam int TAIL_CYCLES  = 40;
    localparam int VEC_W        = LANES * WORD_W;

    logic             clk;
    logic             rstn;
    logic             enable;
    logic [1:0]       mode;
    logic             data_load;
    logic [7:0]       data_in;
    wire  [VEC_W-1:0] aouts;
    wire  [VEC_W-1:0] wouts;
    wire              fire;
    wire              done;

    // Reference copies of both memories
    logic [7:0]  amem [0:4095];
    logic [7:0]  wmem [0:4095];
    logic [31:0] rng_state;

    // Configuration of each run, drawn up front
    int run_out [RUNS];
    int run_in  [RUNS];
    int run_w   [RUNS];
    int run_h   [RUNS];

    // Active configuration and its derived schedule
    int cfg_out;
    int cfg_in;
    int cfg_w;
    int cfg_h;
    int n_win;
    int taps_per_grp;
    int real_steps;
    int exp_fires;

    // Bookkeeping
    string  cur_test;
    int     err_cnt;
    int     check_cnt;
    int     test_err0;
    int     tests_pass;
    int     tests_fail;
    int     fire_cnt;
    bit     watching;
    bit     done_seen;
    longint limit_ns;
    bit     limit_ready;

    conv_feed_top u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .enable    (enable),
        .mode      (mode),
        .data_load (data_load),
        .data_in   (data_in),
        .aouts     (aouts),
        .wouts     (wouts),
        .fire      (fire),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////

    // xorshift32
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic void set_config(input int idx);
        cfg_out      = run_out[idx];
        cfg_in       = run_in[idx];
        cfg_w        = run_w[idx];
        cfg_h        = run_h[idx];
        n_win        = (cfg_w - 2) * (cfg_h - 2);
        taps_per_grp = 9 * cfg_in;
        // Groups of 16 windows, one step per tap
        real_steps   = ((n_win + 15) / 16) * taps_per_grp;
        exp_fires    = real_steps + 15;
    endfunction

    // Activation of lane l at unskewed step t
    function automatic logic [7:0] act_at(input int t, input int l);
        int tap;
        int ch;
        int kr;
        int kc;
        int wi;
        int col;
        int row;
        tap = t % taps_per_grp;
        ch  = tap / 9;
        kr  = (tap % 9) / 3;
        kc  = tap % 3;
        wi  = (t / taps_per_grp) * 16 + l;
        if (wi >= n_win) begin
            return 8'h00;
        end
        // Windows run along a row first
        col = wi % (cfg_w - 2);
        row = wi / (cfg_w - 2);
        return amem[ch * cfg_w * cfg_h + (row + kr) * cfg_w + col + kc];
    endfunction

    // Weight of lane k at unskewed step t
    function automatic logic [7:0] wgt_at(input int t, input int k);
        if (k >= cfg_out) begin
            return 8'h00;
        end
        return wmem[k * taps_per_grp + t % taps_per_grp];
    endfunction

    // Output step s, lane i carries step s-i
    function automatic logic [VEC_W-1:0] skewed_vec(input int s, input bit is_wgt);
        logic [VEC_W-1:0] v;
        int               src;
        v = '0;
        for (int i = 0; i < LANES; i++) begin
            src = s - i;
            if (src >= 0 && src < real_steps) begin
                v[i*WORD_W +: WORD_W] = is_wgt ? wgt_at(src, i) : act_at(src, i);
            end
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////////////////////////

    task automatic report_value(input string what, input logic [VEC_W-1:0] exp_v,
                                input logic [VEC_W-1:0] act_v);
        err_cnt++;
        $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
    endtask

    task automatic report_count(input string what, input int exp_n, input int act_n);
        err_cnt++;
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp_n, act_n);
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("ERROR in %s: %s", cur_test, msg);
    endtask

    task automatic finish_test();
        if (err_cnt == test_err0) begin
            tests_pass++;
            $display("PASS %s", cur_test);
        end else begin
            tests_fail++;
            $display("FAIL %s with %0d errors", cur_test, err_cnt - test_err0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (watching) begin
            if (fire === 1'b1) begin
                check_cnt++;
                if (done_seen) begin
                    report_problem("fire pulse seen after done had risen");
                end else if (fire_cnt >= exp_fires) begin
                    report_problem("more fire pulses than the schedule allows");
                end
                if (aouts !== skewed_vec(fire_cnt, 1'b0)) begin
                    report_value($sformatf("aouts step %0d", fire_cnt),
                                 skewed_vec(fire_cnt, 1'b0), aouts);
                end
                if (wouts !== skewed_vec(fire_cnt, 1'b1)) begin
                    report_value($sformatf("wouts step %0d", fire_cnt),
                                 skewed_vec(fire_cnt, 1'b1), wouts);
                end
                fire_cnt++;
            end
            // Done must follow the very last pulse
            if (done === 1'b1 && !done_seen) begin
                done_seen = 1'b1;
                check_cnt++;
                if (fire_cnt != exp_fires) begin
                    report_count("fire pulses before done", exp_fires, fire_cnt);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Host side drivers
    ////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rstn      = 1'b0;
        enable    = 1'b0;
        data_load = 1'b0;
        mode      = MODE_CFG;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    task automatic send_byte(input logic [1:0] m, input logic [7:0] b);
        @(posedge clk);
        #1;
        mode      = m;
        enable    = 1'b1;
        data_load = 1'b1;
        data_in   = b;
    endtask

    task automatic end_load();
        @(posedge clk);
        #1;
        data_load = 1'b0;
    endtask

    task automatic check_idle();
        @(negedge clk);
        check_cnt++;
        if (fire !== 1'b0) begin
            report_value("fire after reset", '0, fire);
        end
        if (done !== 1'b0) begin
            report_value("done after reset", '0, done);
        end
        if (aouts !== '0) begin
            report_value("aouts after reset", '0, aouts);
        end
        if (wouts !== '0) begin
            report_value("wouts after reset", '0, wouts);
        end
    endtask

    task automatic run_case(input int idx, input bit with_pause);
        logic [31:0] r;
        int          nbytes;
        int          pause_left;
        int          budget;

        set_config(idx);
        watching  = 1'b0;
        cur_test  = $sformatf("run%0d_reset", idx);
        test_err0 = err_cnt;
        apply_reset();
        check_idle();
        finish_test();

        cur_test  = $sformatf("run%0d_compute_o%0d_i%0d_w%0d_h%0d%s", idx, cfg_out, cfg_in,
                              cfg_w, cfg_h, with_pause ? "_paused" : "");
        test_err0 = err_cnt;
        // Configuration bytes in host order
        send_byte(MODE_CFG, 8'(cfg_out));
        send_byte(MODE_CFG, 8'(cfg_in));
        send_byte(MODE_CFG, 8'(cfg_w));
        send_byte(MODE_CFG, 8'(cfg_h));
        // Kernels for all 16 lanes, so masked lanes hold data too
        nbytes = LANES * taps_per_grp;
        for (int a = 0; a < nbytes; a++) begin
            r       = next_rand();
            wmem[a] = r[7:0];
            send_byte(MODE_WGT, r[7:0]);
        end
        nbytes = cfg_in * cfg_w * cfg_h;
        for (int a = 0; a < nbytes; a++) begin
            r       = next_rand();
            amem[a] = r[7:0];
            send_byte(MODE_ACT, r[7:0]);
        end
        end_load();

        fire_cnt   = 0;
        done_seen  = 1'b0;
        watching   = 1'b1;
        pause_left = 0;
        budget     = with_pause ? PAUSE_BUDGET : 0;
        mode       = MODE_RUN;
        enable     = 1'b1;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            if (pause_left > 0) begin
                enable = 1'b0;
                pause_left--;
            end else begin
                enable = 1'b1;
                r      = next_rand();
                // Pauses only once outputs are flowing
                if (budget > 0 && fire_cnt > 0 && r[4:0] == 5'd0) begin
                    pause_left = 1 + int'(r[15:8]) % 24;
                    if (pause_left > budget) begin
                        pause_left = budget;
                    end
                    budget -= pause_left;
                end
            end
        end
        enable = 1'b1;
        // A paused run has to drop enable at least once
        if (with_pause) begin
            check_cnt++;
            if (budget == PAUSE_BUDGET) begin
                report_problem("enable was never dropped during compute");
            end
        end
        // Quiet tail, any extra pulse shows up in the monitor
        repeat (TAIL_CYCLES) @(posedge clk);
        check_cnt++;
        if (fire_cnt != exp_fires) begin
            report_count("fire count", exp_fires, fire_cnt);
        end
        watching = 1'b0;
        finish_test();
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog and main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        wait (limit_ready);
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the simulation did not finish", limit_ns);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0] r;

        rstn        = 1'b0;
        enable      = 1'b0;
        mode        = MODE_CFG;
        data_load   = 1'b0;
        data_in     = 8'h00;
        rng_state   = 32'hcc11;
        err_cnt     = 0;
        check_cnt   = 0;
        test_err0   = 0;
        tests_pass  = 0;
        tests_fail  = 0;
        fire_cnt    = 0;
        watching    = 1'b0;
        done_seen   = 1'b0;
        limit_ready = 1'b0;
        limit_ns    = 0;

        // Draw every configuration first to size the time limit
        for (int k = 0; k < RUNS; k++) begin
            r          = next_rand();
            run_out[k] = 1 + int'(r[7:0]) % 16;
            run_w[k]   = 3 + int'(r[15:8]) % 18;
            run_in[k]  = 1 + int'(r[23:16]) % 4;
            run_h[k]   = 3 + int'(r[31:24]) % 18;
            set_config(k);
            limit_ns += 10 * (2 * (real_steps + 15) * 16 + 4 + LANES * taps_per_grp +
                              cfg_in * cfg_w * cfg_h + PAUSE_BUDGET + TAIL_CYCLES + 50);
        end
        limit_ready = 1'b1;

        // Last run drops enable in random stretches
        for (int k = 0; k < RUNS; k++) begin
            run_case(k, k == RUNS - 1);
        end

        $display("tests=%0d passed=%0d failed=%0d checks=%0d errors=%0d",
                 tests_pass + tests_fail, tests_pass, tests_fail, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: conv_feed.f
hw/conv_feed_pkg.sv
hw/tap_if.sv
hw/tap_sequencer.sv
hw/act_feeder.sv
hw/wgt_feeder.sv
hw/skew_stage.sv
hw/conv_feed_top.sv
bench/conv_feed_tb.sv
